// File: cp0_macros.svh
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// Register addresses are {rd, sel}
`define CP0_ADDR_STATUS     8'h60   // rd 12 sel 0
`define CP0_ADDR_CAUSE      8'h68   // rd 13 sel 0
`define CP0_ADDR_EPC        8'h70   // rd 14 sel 0
`define CP0_ADDR_BADVADDR   8'h40   // rd 8 sel 0
`define CP0_ADDR_COUNT      8'h48   // rd 9 sel 0
`define CP0_ADDR_COMPARE    8'h58   // rd 11 sel 0
`define CP0_ADDR_EBASE      8'h79   // rd 15 sel 1

`define CP0_STATUS_RESET    32'h0040_0000   // Bev only
`define CP0_COMPARE_RESET   32'hFFFF_FFFF
`define CP0_EBASE_RESET     32'h8000_0000

`define CP0_BOOT_EX_BASE        32'hBFC0_0200
`define CP0_GENERAL_EX_OFFSET   32'h0000_0180

`define CP0_EXT_INT_NUM     6
`define CP0_EXC_CODE_W      5
`define CP0_REG_ADDR_W      8

`endif

// File: cp0_pkg.sv
`default_nettype none
`include "cp0_macros.svh"

package cp0_pkg;

    typedef enum logic [`CP0_EXC_CODE_W-1:0] {
        EXC_NONE, EXC_INT, EXC_ADEL, EXC_ADES, EXC_SYS,
        EXC_BP, EXC_RI, EXC_CPU, EXC_OV, EXC_TRAP
    } exc_kind_e;

    typedef struct packed {
        logic [2:0] rsv31_29;
        logic       cu0;        // 28
        logic [4:0] rsv27_23;
        logic       bev;        // 22
        logic [5:0] rsv21_16;
        logic [7:0] im;         // 15..8
        logic [2:0] rsv7_5;
        logic       um;         // 4
        logic       rsv3;
        logic       erl;        // 2
        logic       exl;        // 1
        logic       ie;         // 0
    } status_t;

    typedef struct packed {
        logic                       bd;         // 31
        logic                       ti;         // 30
        logic [1:0]                 ce;         // 29..28
        logic [11:0]                rsv27_16;
        logic [7:0]                 ip;         // 15..8
        logic                       rsv7;
        logic [`CP0_EXC_CODE_W-1:0] exc_code;   // 6..2
        logic [1:0]                 rsv1_0;
    } cause_t;

    // One mtc0 word, seen through either register layout
    typedef union packed {
        status_t     status;
        cause_t      cause;
        logic [31:0] word;
    } cp0_word_u;

    typedef struct packed {
        logic        valid;
        logic        mtc0;
        logic        eret;
        logic        bd;        // Instruction sits in a delay slot
        logic        ex;
        exc_kind_e   kind;
        logic [4:0]  rd;
        logic [2:0]  sel;
        logic [31:0] pc;
        logic [31:0] data;      // ALU result
    } commit_t;

    typedef struct packed {
        logic status;
        logic cause;
        logic epc;
        logic badvaddr;
        logic count;
        logic compare;
        logic ebase;
    } cp0_wr_t;

    typedef struct packed {
        logic                       taken;
        logic                       bd;
        logic [`CP0_EXC_CODE_W-1:0] exc_code;
        logic                       cpu_unusable;
        logic [31:0]                pc_adjusted;
    } exc_event_t;

endpackage

`default_nettype wire

// File: cp0_commit_decode.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_commit_decode import cp0_pkg::*; (
    input  commit_t    commit,
    input  logic       status_exl,
    output cp0_wr_t    wr,
    output cp0_word_u  wdata,
    output exc_event_t evt,
    output logic       eret_flush
);

    logic [`CP0_REG_ADDR_W-1:0] addr;
    logic                       we;
    logic [`CP0_EXC_CODE_W-1:0] code;

    assign addr       = {commit.rd, commit.sel};
    assign we         = commit.valid && commit.mtc0 && !commit.ex;
    assign eret_flush = commit.valid && commit.eret && !commit.ex;

    assign wr.status   = we && (addr == `CP0_ADDR_STATUS);
    assign wr.cause    = we && (addr == `CP0_ADDR_CAUSE);
    assign wr.epc      = we && (addr == `CP0_ADDR_EPC);
    assign wr.badvaddr = we && (addr == `CP0_ADDR_BADVADDR);
    assign wr.count    = we && (addr == `CP0_ADDR_COUNT);
    assign wr.compare  = we && (addr == `CP0_ADDR_COMPARE);
    assign wr.ebase    = we && (addr == `CP0_ADDR_EBASE);

    assign wdata.word = commit.data;    // Each register group picks its own layout

    always_comb begin
        case (commit.kind)
            EXC_INT:  code = 5'd0;
            EXC_ADEL: code = 5'd4;
            EXC_ADES: code = 5'd5;
            EXC_SYS:  code = 5'd8;
            EXC_BP:   code = 5'd9;
            EXC_RI:   code = 5'd10;
            EXC_CPU:  code = 5'd11;
            EXC_OV:   code = 5'd12;
            EXC_TRAP: code = 5'd13;
            default:  code = 5'd0;
        endcase
    end

    assign evt.taken        = commit.valid && commit.ex;
    assign evt.bd           = commit.bd && !status_exl;     // Nested entry keeps the first slot
    assign evt.exc_code     = code;
    assign evt.cpu_unusable = evt.taken && (commit.kind == EXC_CPU);
    assign evt.pc_adjusted  = commit.bd ? commit.pc - 32'd4 : commit.pc;   // Point at the branch

endmodule

`default_nettype wire

// File: cp0_timer.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_timer import cp0_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  cp0_wr_t     wr,
    input  cp0_word_u   wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        ti
);

    logic tick;     // Half-rate enable for Count

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= 32'd0;
            compare <= `CP0_COMPARE_RESET;
            ti      <= 1'b0;
        end else begin
            tick <= !tick;
            if (wr.count) begin
                count <= wdata.word;
            end else if (tick) begin
                count <= count + 32'd1;
            end
            if (wr.compare) begin
                compare <= wdata.word;
            end
            if (wr.compare) begin
                ti <= 1'b0;             // Compare write acknowledges the interrupt
            end else if (count == compare) begin
                ti <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: cp0_status_cause.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_status_cause import cp0_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  cp0_wr_t                     wr,
    input  cp0_word_u                   wdata,
    input  exc_event_t                  evt,
    input  logic                        eret_flush,
    input  logic [`CP0_EXT_INT_NUM-1:0] ext_int,
    input  logic                        ti,
    output status_t                     status,
    output cause_t                      cause,
    output logic                        int_pending
);

    status_t status_q;
    cause_t  cause_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= `CP0_STATUS_RESET;
        end else begin
            if (wr.status) begin
                status_q.cu0 <= wdata.status.cu0;
                status_q.bev <= wdata.status.bev;
                status_q.im  <= wdata.status.im;
                status_q.um  <= wdata.status.um;
                status_q.erl <= wdata.status.erl;
                status_q.ie  <= wdata.status.ie;
            end
            if (evt.taken) begin
                status_q.exl <= 1'b1;
            end else if (eret_flush) begin
                status_q.exl <= 1'b0;
            end else if (wr.status) begin
                status_q.exl <= wdata.status.exl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            // Hardware lines land in IP7..IP2, timer shares IP7
            cause_q.ip[7:2] <= ext_int | {ti, {(`CP0_EXT_INT_NUM-1){1'b0}}};
            if (wr.cause) begin
                cause_q.ip[1:0] <= wdata.cause.ip[1:0];     // Software interrupts
            end
            if (evt.taken) begin
                cause_q.exc_code <= evt.exc_code;
                if (!status_q.exl) begin
                    cause_q.bd <= evt.bd;
                end
                if (evt.cpu_unusable) begin
                    cause_q.ce <= 2'd1;     // Only CP0 exists here
                end
            end
        end
    end

    always_comb begin
        cause    = cause_q;
        cause.ti = ti;          // Live view of the timer flag
    end

    assign status = status_q;

    assign int_pending = (|(cause_q.ip & status_q.im)) && status_q.ie && !status_q.exl;

endmodule

`default_nettype wire

// File: cp0_exc_capture.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_exc_capture import cp0_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  cp0_wr_t     wr,
    input  cp0_word_u   wdata,
    input  exc_event_t  evt,
    input  exc_kind_e   commit_kind,
    input  logic [31:0] commit_pc,
    input  logic [31:0] commit_data,
    input  logic        status_exl,
    input  logic        status_bev,
    output logic [31:0] epc,
    output logic [31:0] badvaddr,
    output logic [31:0] ebase,
    output logic [31:0] exc_vector
);

    always_ff @(posedge clk) begin
        if (evt.taken && !status_exl) begin
            epc <= evt.pc_adjusted;
        end else if (wr.epc) begin
            epc <= wdata.word;
        end
    end

    always_ff @(posedge clk) begin
        if (evt.taken) begin
            if (commit_kind == EXC_ADES) begin
                badvaddr <= commit_data;
            end else if (commit_kind == EXC_ADEL) begin
                // Fetch fault if the pc itself is misaligned, else a load
                badvaddr <= (commit_pc[1:0] != 2'b00) ? commit_pc : commit_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= `CP0_EBASE_RESET;
        end else if (wr.ebase) begin
            ebase[29:12] <= wdata.word[29:12];  // Exception base field only
        end
    end

    assign exc_vector = (status_bev ? `CP0_BOOT_EX_BASE : ebase) + `CP0_GENERAL_EX_OFFSET;

endmodule

`default_nettype wire

// File: cp0_read_mux.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_read_mux import cp0_pkg::*; (
    input  logic [4:0]  rd,
    input  logic [2:0]  sel,
    input  status_t     status,
    input  cause_t      cause,
    input  logic [31:0] epc,
    input  logic [31:0] badvaddr,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic [31:0] ebase,
    output logic [31:0] rdata
);

    always_comb begin
        case ({rd, sel})
            `CP0_ADDR_STATUS:   rdata = status;
            `CP0_ADDR_CAUSE:    rdata = cause;
            `CP0_ADDR_EPC:      rdata = epc;
            `CP0_ADDR_BADVADDR: rdata = badvaddr;
            `CP0_ADDR_COUNT:    rdata = count;
            `CP0_ADDR_COMPARE:  rdata = compare;
            `CP0_ADDR_EBASE:    rdata = ebase;
            default:            rdata = 32'd0;     // Unimplemented register
        endcase
    end

endmodule

`default_nettype wire

// File: cp0_top.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_top import cp0_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  commit_t                     commit,
    input  logic [`CP0_EXT_INT_NUM-1:0] ext_int,
    output logic [31:0]                 rdata,
    output logic [31:0]                 epc,
    output logic [31:0]                 exc_vector,
    output logic                        eret_flush,
    output logic                        int_pending
);

    cp0_wr_t     wr;
    cp0_word_u   wdata;
    exc_event_t  evt;
    logic [31:0] count;
    logic [31:0] compare;
    logic        ti;
    status_t     status;
    cause_t      cause;
    logic [31:0] badvaddr;
    logic [31:0] ebase;

    cp0_commit_decode u_decode (
        .status_exl (status.exl),
        .*
    );

    cp0_timer u_timer (.*);

    cp0_status_cause u_status_cause (.*);

    cp0_exc_capture u_exc_capture (
        .commit_kind (commit.kind),
        .commit_pc   (commit.pc),
        .commit_data (commit.data),
        .status_exl  (status.exl),
        .status_bev  (status.bev),
        .*
    );

    cp0_read_mux u_read_mux (
        .rd  (commit.rd),
        .sel (commit.sel),
        .*
    );

endmodule

`default_nettype wire

// File: cp0_chk.sv
`default_nettype none

module cp0_chk import cp0_pkg::*; (
    input logic        clk,
    input logic        reset,
    input commit_t     commit,
    input logic        eret_flush,
    input logic        int_pending,
    input logic [31:0] exc_vector
);

    timeunit 1ns;
    timeprecision 100ps;

    // A faulting eret must not redirect fetch
    a_no_flush_on_ex: assert property (
        @(posedge clk) disable iff (reset) !(eret_flush && commit.ex))
        else $error("eret_flush raised together with commit.ex");

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> !int_pending)
        else $error("int_pending high in the cycle after reset");

    // Boot vector ends in 0x380, so only the low nine bits are fixed
    a_vector_offset: assert property (
        @(posedge clk) disable iff (reset) exc_vector[8:0] == 9'h180)
        else $error("exc_vector %h lacks the general exception offset", exc_vector);

endmodule

`default_nettype wire

// File: cp0_tb.sv
`default_nettype none
`include "cp0_macros.svh"

module cp0_tb import cp0_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                        clk;
    logic                        reset;
    commit_t                     commit;
    logic [`CP0_EXT_INT_NUM-1:0] ext_int;
    logic [31:0]                 rdata;
    logic [31:0]                 epc;
    logic [31:0]                 exc_vector;
    logic                        eret_flush;
    logic                        int_pending;

    string       lines[$];             // Step lines from the cases file
    logic [31:0] rng = 32'h6e95;
    int          tests = 0;
    int          fails = 0;
    int          bad_lines = 0;
    int          cycles = 0;
    int          limit = 0;

    cp0_top dut0 (.*);

    bind cp0_top cp0_chk chk0 (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .eret_flush  (eret_flush),
        .int_pending (int_pending),
        .exc_vector  (exc_vector)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without reaching the end of the cases", cycles);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic apply_commit(input logic valid, input logic mtc0, input logic eret,
                                input logic bd, input logic ex, input logic [31:0] kind,
                                input logic [31:0] rd, input logic [31:0] sel,
                                input logic [31:0] pc, input logic [31:0] data);
        commit_t c;
        c = {valid, mtc0, eret, bd, ex, kind[4:0], rd[4:0], sel[2:0], pc, data};  // commit_t order
        @(posedge clk);
        commit <= c;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        tests++;
        assert (actual === expected) else begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            fails++;
        end
        $display("%s %s", (actual === expected) ? "PASS" : "FAIL", name);
    endtask

    task automatic run_step(input string line);
        string       fields[$];
        string       word;
        string       op;
        string       name;
        logic [31:0] rd;
        logic [31:0] sel;
        logic [31:0] kind;
        logic [31:0] bd;
        logic [31:0] pc;
        logic [31:0] data;
        logic [31:0] expected;
        logic [31:0] waited;
        byte         c;
        int          last;
        word = "";
        for (int i = 0; i < line.len(); i++) begin
            c = line.getc(i);
            if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
                if (word.len() > 0) begin
                    fields.push_back(word);
                end
                word = "";
            end else begin
                word = {word, line.substr(i, i)};
            end
        end
        if (word.len() > 0) begin
            fields.push_back(word);
        end
        last = fields.size() - 1;
        if (fields.size() >= 9) begin
            op       = fields[0];
            name     = fields[1];
            rd       = fields[2].atohex();
            sel      = fields[3].atohex();
            // Last five columns are counted from the end of the line
            kind     = fields[last-4].atohex();
            bd       = fields[last-3].atohex();
            pc       = fields[last-2].atohex();
            data     = fields[last-1].atohex();
            expected = fields[last].atohex();
        end
        if (fields.size() < 9) begin
            $display("Case line could not be parsed: %s", line);
            bad_lines++;
        end else if (op == "W") begin
            apply_commit(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 0, rd, sel, pc, data);
        end else if (op == "X") begin
            if (data == 32'd0) begin
                rng = next_random(rng);
                data = rng;     // Filler ALU result
            end
            apply_commit(1'b1, 1'b0, 1'b0, bd[0], 1'b1, kind, rd, sel, pc, data);
        end else if (op == "E") begin
            // A nonzero kind turns the eret into a faulting one
            apply_commit(1'b1, 1'b0, 1'b1, 1'b0, kind != 0, kind, rd, sel, pc, data);
            @(negedge clk);
            check_value(name, expected, {31'd0, eret_flush});
        end else if (op == "R") begin
            apply_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, rd, sel, pc, data);
            @(negedge clk);
            check_value(name, expected, rdata);
            if ({rd[4:0], sel[2:0]} == `CP0_ADDR_EPC) begin
                check_value({name, "_port"}, expected, epc);    // Dedicated EPC output
            end
        end else if (op == "V") begin
            apply_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, rd, sel, pc, data);
            @(negedge clk);
            check_value(name, expected, exc_vector);
        end else if (op == "T") begin
            apply_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, rd, sel, pc, data);
            ext_int <= pc[`CP0_EXT_INT_NUM-1:0];
            waited = 32'd0;
            @(negedge clk);
            while (int_pending !== expected[0] && waited < data) begin
                @(negedge clk);
                waited = waited + 32'd1;
            end
            tests++;
            assert (int_pending === expected[0]) else begin
                $display("** Error: %s int_pending did not become %0d within %0d cycles",
                         name, expected[0], data);
                fails++;
            end
            $display("%s %s", (int_pending === expected[0]) ? "PASS" : "FAIL", name);
        end else begin
            $display("Unknown operation %s in the cases file", op);
            bad_lines++;
        end
    endtask

    initial begin : main
        int    fd;
        string line;
        commit  = '0;
        ext_int = '0;
        reset   = 1'b1;
        fd = $fopen("cp0_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open cp0_cases.txt");
            bad_lines++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit = (lines.size() + 1) * 64;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (lines[i]) begin
            run_step(lines[i]);
        end
        apply_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, 0, 0, 0, 0);
        @(posedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d bad case lines",
                 tests, tests - fails, fails, bad_lines);
        if (fails == 0 && bad_lines == 0 && tests > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cp0_cases.txt
# op name rd sel kind bd pc data expected, numbers in hex, kind is the exc_kind_e code
# T drives ext_int from pc, waits up to data cycles for int_pending to equal expected
W status_all c 0 0 0 0 ffffffff 0
R status_rd c 0 0 0 0 0 1040ff17
W cause_all d 0 0 0 0 ffffffff 0
R cause_rd d 0 0 0 0 0 00000300
W cause_clr d 0 0 0 0 0 0
W ebase_all f 1 0 0 0 ffffffff 0
R ebase_rd f 1 0 0 0 0 bffff000
W status_boot c 0 0 0 0 00400000 0
X sys_in_slot 0 0 4 1 80001004 0 0
R epc_slot e 0 0 0 0 0 80001000
R cause_slot d 0 0 0 0 0 80000020
R status_exl c 0 0 0 0 0 00400002
X bp_nested 0 0 5 0 80002000 0 0
R epc_kept e 0 0 0 0 0 80001000
R cause_nested d 0 0 0 0 0 80000024
X cpu_unusable 0 0 7 0 80003000 0 0
R cause_ce d 0 0 0 0 0 9000002c
X adel_fetch 0 0 2 0 80004002 0 0
R badvaddr_pc 8 0 0 0 0 0 80004002
X adel_load 0 0 2 0 80004000 12345678 0
R badvaddr_load 8 0 0 0 0 0 12345678
X ades_store 0 0 3 0 80004000 9abcdef1 0
R badvaddr_store 8 0 0 0 0 0 9abcdef1
E eret_with_ex 0 0 4 0 80005000 0 0
E eret_flush 0 0 0 0 80005000 0 1
R status_after_eret c 0 0 0 0 0 00400000
V vector_boot 0 0 0 0 0 0 bfc00380
W status_clear c 0 0 0 0 0 0
W ebase_set f 1 0 0 0 0 00123000 0
V vector_ebase 0 0 0 0 0 0 80123180
W status_im7 c 0 0 0 0 0 00008001 0
W count_set 9 0 0 0 0 00000100 0
W compare_set b 0 0 0 0 0 00000108 0
T timer_irq 0 0 0 0 0 28 1
R cause_ti d 0 0 0 0 0 d0008020
W compare_ack b 0 0 0 0 0 00100000 0
T timer_cleared 0 0 0 0 0 4 0
W status_im2 c 0 0 0 0 0 00000401 0
T ext_int0 0 0 0 0 1 8 1
T ext_int0_low 0 0 0 0 0 8 0

// File: project.f
+incdir+.
cp0_pkg.sv
cp0_commit_decode.sv
cp0_timer.sv
cp0_status_cause.sv
cp0_exc_capture.sv
cp0_read_mux.sv
cp0_top.sv
cp0_chk.sv
cp0_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cp0_tb -f project.f -o cp0_sim
./obj_dir/cp0_sim | tee sim.log
if grep -q 'All tests passed!' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
